// File: Makefile
TOOL     = verilator
TOP      = tb_gt_reset
FILELIST = src.f
FLAGS    = --binary --timing --assert --timescale 1ns/100ps
BUILD    = obj_dir
LOG      = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -Mdir $(BUILD) -f $(FILELIST)

run: build
	-./$(BUILD)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	@if grep -q "TEST FAIL" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "TEST PASS" $(LOG); then echo "Simulation ended without a result"; exit 1; fi

lint:
	$(TOOL) --lint-only --timing --assert --timescale 1ns/100ps --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD) $(LOG)

// File: src.f
+incdir+verilog
verilog/gt_reset_state_pkg.sv
verilog/gt_reset_io_pkg.sv
verilog/level_sync.sv
verilog/settle_timer.sv
verilog/reset_all_sequencer.sv
verilog/chan_reset_fsm.sv
verilog/gt_reset_top.sv
tb/gt_model.sv
tb/tb_gt_reset.sv

// File: tb/gt_model.sv
/* Behavioral transceiver model that answers PLL and datapath resets
   with lock, CDR lock and reset-done levels after random delays */
module gt_model (
  input  logic gtwiz_reset_clk_freerun_in,
  input  logic pll_reset,
  input  logic dp_reset,
  input  logic userrdy,
  input  logic lock_kill,
  input  logic cdr_en,
  output logic plllock,
  output logic resetdone,
  output logic cdrlock
);

  timeunit 1ns;
  timeprecision 100ps;

  integer seed = 32'h70c4;
  int     lock_wait = 5;
  int     done_wait = 3;
  logic   lock_q = 1'b0;
  logic   done_q = 1'b0;
  logic   cdr_q = 1'b0;

  assign plllock   = lock_q;
  assign resetdone = done_q;
  assign cdrlock   = cdr_q;

  // Levels change 1 ns after the rising edge, like all other stimulus
  always begin
    @(posedge gtwiz_reset_clk_freerun_in);
    #1;
    // The lock delay is redrawn while the PLL sits in reset
    // so the count starts when pll_reset falls
    if (pll_reset || lock_kill) begin
      lock_q    = 1'b0;
      lock_wait = 5 + int'($unsigned($random(seed)) % 16);
    end else if (!lock_q) begin
      lock_wait = lock_wait - 1;
      if (lock_wait <= 0) begin
        lock_q = 1'b1;
      end
    end
    // Reset done needs the datapath out of reset and the user side ready
    if (dp_reset) begin
      done_q    = 1'b0;
      done_wait = 3 + int'($unsigned($random(seed)) % 8);
    end else if (userrdy && !done_q) begin
      done_wait = done_wait - 1;
      if (done_wait <= 0) begin
        done_q = 1'b1;
      end
    end
    // CDR lock tracks PLL lock, withheld when disabled
    cdr_q = lock_q && cdr_en;
  end

endmodule

// File: tb/tb_gt_reset.sv
/* Testbench for the transceiver reset helper, with two transceiver models,
   a fixed stimulus sequence and concurrent checks */
`include "gt_reset_params.svh"

module tb_gt_reset;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int TIMEOUT_CYCLES = 2000;
  // Request cycle, one branch cycle, PLL hold, then the register update
  localparam int RX_PLL_FALL    = `GT_PLL_RESET_CYCLES + 3;
  // One more cycle from rx_done high to the transmit request
  localparam int TX_PLL_FALL    = `GT_PLL_RESET_CYCLES + 4;
  localparam int CDR_FALL       = `GT_CDR_TIMEOUT_CYCLES + 1;
  localparam int DP_REQ_DELAY   = `GT_CDC_STAGES + 1;

  typedef enum int {w_rx_done, w_tx_done, w_gtrxreset} watch_t;

  logic gtwiz_reset_clk_freerun_in = 1'b0;
  logic gtwiz_reset_all_sync;
  logic tx_datapath_req, rx_datapath_req;
  logic userclk_tx_active, userclk_rx_active;
  logic plllock_tx, txresetdone, plllock_rx, rxcdrlock, rxresetdone;
  logic pllreset_tx, gttxreset, txprogdivreset, txuserrdy;
  logic pllreset_rx, gtrxreset, rxprogdivreset, rxuserrdy;
  logic tx_done, rx_done, rx_cdr_stable;
  // Model controls and phase flags for the checks
  logic rx_cdr_en, tx_lock_kill, dp_phase, quiet;
  int   errors = 0;
  int   timeouts = 0;

  always #2 gtwiz_reset_clk_freerun_in = ~gtwiz_reset_clk_freerun_in;

  gt_reset_top dut_i (.*);

  gt_model tx_model_i (
    .gtwiz_reset_clk_freerun_in (gtwiz_reset_clk_freerun_in),
    .pll_reset (pllreset_tx), .dp_reset (gttxreset), .userrdy (txuserrdy),
    .lock_kill (tx_lock_kill), .cdr_en (1'b0),
    .plllock (plllock_tx), .resetdone (txresetdone), .cdrlock ()
  );

  gt_model rx_model_i (
    .gtwiz_reset_clk_freerun_in (gtwiz_reset_clk_freerun_in),
    .pll_reset (pllreset_rx), .dp_reset (gtrxreset), .userrdy (rxuserrdy),
    .lock_kill (1'b0), .cdr_en (rx_cdr_en),
    .plllock (plllock_rx), .resetdone (rxresetdone), .cdrlock (rxcdrlock)
  );

  task automatic report_mismatch(input string msg);
    errors++;
    $display("mismatch at %0t: %s", $time, msg);
  endtask

  function automatic logic watched(input watch_t sel);
    case (sel)
      w_rx_done: return rx_done;
      w_tx_done: return tx_done;
      default:   return gtrxreset;
    endcase
  endfunction

  // Polls 1 ns after each edge, skipped once any wait has timed out
  task automatic wait_until(input watch_t sel, input logic level, input string what);
    int n;
    if (timeouts != 0) return;
    n = 0;
    while (watched(sel) !== level && n < TIMEOUT_CYCLES) begin
      @(posedge gtwiz_reset_clk_freerun_in);
      #1;
      n++;
    end
    if (watched(sel) !== level) begin
      timeouts++;
      $display("timeout at %0t: %s did not happen in time", $time, what);
    end
  endtask

  task automatic apply_reset();
    gtwiz_reset_all_sync = 1'b1;
    repeat (2) @(posedge gtwiz_reset_clk_freerun_in);
    #1;
    gtwiz_reset_all_sync = 1'b0;
  endtask

  task automatic finish_run();
    $display("result: %0d mismatches, %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  endtask

  // ---------------------------------------------------------------------
  // Checks
  // ---------------------------------------------------------------------

  // Reset values as the first free cycle sees them
  a_reset_values: assert property (@(posedge gtwiz_reset_clk_freerun_in)
    $fell(gtwiz_reset_all_sync) |-> !tx_done && !rx_done && gttxreset && gtrxreset
      && txprogdivreset && rxprogdivreset && pllreset_rx && !txuserrdy && !rxuserrdy
      && !rx_cdr_stable && (pllreset_tx || `GT_SHARED_PLL != 0))
    else report_mismatch("outputs not at their reset values after reset");

  // The receive PLL request goes out in the first cycle after reset
  a_rx_pll_hold: assert property (@(posedge gtwiz_reset_clk_freerun_in)
    disable iff (gtwiz_reset_all_sync)
    $fell(pllreset_rx) |-> $past(gtwiz_reset_all_sync, RX_PLL_FALL + 1)
      && !$past(gtwiz_reset_all_sync, RX_PLL_FALL))
    else report_mismatch("pllreset_rx fell at the wrong time");

  a_tx_pll_hold: assert property (@(posedge gtwiz_reset_clk_freerun_in)
    disable iff (gtwiz_reset_all_sync)
    (`GT_SHARED_PLL == 0) && $fell(pllreset_tx) |-> $past(rx_done, TX_PLL_FALL)
      && !$past(rx_done, TX_PLL_FALL + 1))
    else report_mismatch("pllreset_tx fell at the wrong time");

  a_tx_after_rx: assert property (@(posedge gtwiz_reset_clk_freerun_in)
    disable iff (gtwiz_reset_all_sync) $rose(tx_done) |-> rx_done)
    else report_mismatch("tx_done rose while rx_done was low");

  a_tx_userrdy: assert property (@(posedge gtwiz_reset_clk_freerun_in)
    disable iff (gtwiz_reset_all_sync) txuserrdy |-> !gttxreset)
    else report_mismatch("txuserrdy high during gttxreset");

  a_rx_userrdy: assert property (@(posedge gtwiz_reset_clk_freerun_in)
    disable iff (gtwiz_reset_all_sync) rxuserrdy |-> !gtrxreset)
    else report_mismatch("rxuserrdy high during gtrxreset");

  a_tx_done_ready: assert property (@(posedge gtwiz_reset_clk_freerun_in)
    disable iff (gtwiz_reset_all_sync) tx_done |-> txuserrdy)
    else report_mismatch("tx_done high while txuserrdy low");

  a_rx_done_ready: assert property (@(posedge gtwiz_reset_clk_freerun_in)
    disable iff (gtwiz_reset_all_sync) rx_done |-> rxuserrdy)
    else report_mismatch("rx_done high while rxuserrdy low");

  a_no_cdr_stable: assert property (@(posedge gtwiz_reset_clk_freerun_in)
    disable iff (gtwiz_reset_all_sync) !rx_cdr_en |-> !rx_cdr_stable)
    else report_mismatch("rx_cdr_stable high without CDR lock");

  // Without CDR lock the divider reset ends only at the full timeout
  a_cdr_timeout: assert property (@(posedge gtwiz_reset_clk_freerun_in)
    disable iff (gtwiz_reset_all_sync)
    $fell(rxprogdivreset) && !rx_cdr_en |-> $past(gtrxreset, CDR_FALL + 1)
      && !$past(gtrxreset, CDR_FALL))
    else report_mismatch("rxprogdivreset ignored the CDR timeout");

  a_cdr_stable: assert property (@(posedge gtwiz_reset_clk_freerun_in)
    disable iff (gtwiz_reset_all_sync) $rose(rx_done) && rx_cdr_en |-> rx_cdr_stable)
    else report_mismatch("rx_done rose before CDR lock was seen");

  a_dp_req: assert property (@(posedge gtwiz_reset_clk_freerun_in)
    disable iff (gtwiz_reset_all_sync)
    $rose(gtrxreset) |-> $fell(rx_done) && $past(rx_datapath_req, DP_REQ_DELAY))
    else report_mismatch("gtrxreset rose without a matching user request");

  a_dp_phase: assert property (@(posedge gtwiz_reset_clk_freerun_in)
    disable iff (gtwiz_reset_all_sync) dp_phase |-> !pllreset_rx && tx_done)
    else report_mismatch("datapath reset touched the PLL or the transmit side");

  a_quiet: assert property (@(posedge gtwiz_reset_clk_freerun_in)
    disable iff (gtwiz_reset_all_sync)
    quiet |-> !($rose(pllreset_tx) || $rose(gttxreset) || $rose(txprogdivreset)
      || $rose(pllreset_rx) || $rose(gtrxreset) || $rose(rxprogdivreset)
      || $rose(tx_done)))
    else report_mismatch("an output rose after lock loss with no request");

  a_tx_done_fall: assert property (@(posedge gtwiz_reset_clk_freerun_in)
    disable iff (gtwiz_reset_all_sync) $fell(tx_done) |-> tx_lock_kill)
    else report_mismatch("tx_done fell while the PLL stayed locked");

  // ---------------------------------------------------------------------
  // Stimulus
  // ---------------------------------------------------------------------

  initial begin
    gtwiz_reset_all_sync = 1'b1;
    tx_datapath_req      = 1'b0;
    rx_datapath_req      = 1'b0;
    userclk_tx_active    = 1'b1;
    userclk_rx_active    = 1'b1;
    rx_cdr_en            = 1'b0;
    tx_lock_kill         = 1'b0;
    dp_phase             = 1'b0;
    quiet                = 1'b0;

    // Reset all with CDR lock withheld, so the receive side times out
    apply_reset();
    wait_until(w_rx_done, 1'b1, "rx_done rising with CDR lock withheld");
    wait_until(w_tx_done, 1'b1, "tx_done rising after the first reset all");

    // Reset all again with a CDR that locks
    rx_cdr_en = 1'b1;
    apply_reset();
    wait_until(w_rx_done, 1'b1, "rx_done rising with CDR lock");
    wait_until(w_tx_done, 1'b1, "tx_done rising after the second reset all");

    // One-cycle user datapath request on the receive side
    dp_phase        = 1'b1;
    rx_datapath_req = 1'b1;
    @(posedge gtwiz_reset_clk_freerun_in);
    #1;
    rx_datapath_req = 1'b0;
    wait_until(w_gtrxreset, 1'b1, "gtrxreset rising on the user request");
    wait_until(w_rx_done, 1'b0, "rx_done falling on the user request");
    wait_until(w_rx_done, 1'b1, "rx_done rising after the datapath reset");
    dp_phase = 1'b0;

    // Transmit PLL loses lock while idle
    quiet        = 1'b1;
    tx_lock_kill = 1'b1;
    wait_until(w_tx_done, 1'b0, "tx_done falling on lock loss");
    repeat (40) @(posedge gtwiz_reset_clk_freerun_in);
    #1;

    finish_run();
  end

endmodule

// File: verilog/chan_reset_fsm.sv
/* Per-direction reset FSM with PLL, datapath, CDR and user-ready phases */
`include "gt_reset_params.svh"

module chan_reset_fsm #(
  parameter int  HAS_CDR  = 0,
  parameter type status_t = gt_reset_io_pkg::tx_status_t
) (
  input  logic                         gtwiz_reset_clk_freerun_in,
  input  logic                         gtwiz_reset_all_sync,
  input  gt_reset_io_pkg::reset_kind_t req,
  input  logic                         user_dp_req,
  input  status_t                      status,
  input  logic                         resetdone_raw,
  output logic                         pll_reset,
  output logic                         dp_reset,
  output logic                         progdiv_reset,
  output logic                         userrdy,
  output logic                         done
);

  import gt_reset_state_pkg::*;
  import gt_reset_io_pkg::*;

  localparam int TW = `GT_TIMER_WIDTH;
  localparam logic [TW-1:0] SETTLE_LIMIT = TW'(`GT_SETTLE_CYCLES);
  localparam logic [TW-1:0] PLL_LIMIT    = TW'(`GT_PLL_RESET_CYCLES);
  localparam logic [TW-1:0] CDR_LIMIT    = TW'(`GT_CDR_TIMEOUT_CYCLES);

  // A transmit side behind a shared PLL never owns the PLL reset
  localparam logic PLL_RESET_INIT = (HAS_CDR != 0) || (`GT_SHARED_PLL == 0);

  chan_state_t         state;
  chan_state_t         state_d;
  reset_kind_t         kind;
  reset_kind_t         new_kind;
  logic                user_dp_q;
  logic                leave;
  logic                tmr_clr;
  logic                tmr_sat;
  logic [TW-1:0]       tmr_limit;
  logic [$bits(status_t)-1:0] status_bits;
  logic                cdr_lock;

  // The receive bundle carries cdrlock in its top bit
  // On the transmit side that bit is never looked at
  assign status_bits = status;
  assign cdr_lock    = status_bits[$bits(status_t)-1];

  // ---------------------------------------------------------------------
  // Request intake and next state
  // ---------------------------------------------------------------------

  always_comb begin
    // The sequencer wins over a user request in the same cycle
    new_kind = req;
    if (req == kind_none && user_dp_req && !user_dp_q) begin
      new_kind = kind_datapath;
    end

    state_d = state;
    case (state)
      ch_branch: begin
        state_d = (kind == kind_pll_and_datapath) ? ch_pll : ch_datapath;
      end
      ch_pll, ch_datapath: begin
        if (tmr_sat) state_d = ch_wait_lock;
      end
      ch_wait_lock: begin
        if (tmr_sat && status.plllock) begin
          state_d = (HAS_CDR != 0) ? ch_wait_cdr : ch_wait_userrdy;
        end
      end
      // CDR lock or the timeout, whichever comes first
      ch_wait_cdr: begin
        if (tmr_sat || cdr_lock) state_d = ch_wait_userrdy;
      end
      ch_wait_userrdy: begin
        if (tmr_sat && status.userclk_active) state_d = ch_wait_resetdone;
      end
      // Resetdone is taken unsynchronized, the settle stall covers it
      ch_wait_resetdone: begin
        if (tmr_sat && resetdone_raw) state_d = ch_idle;
      end
      default: begin
        state_d = state;
      end
    endcase

    // Any new request restarts the sequence
    if (new_kind != kind_none) begin
      state_d = ch_branch;
    end
  end

  assign leave = (state_d != state);

  // ---------------------------------------------------------------------
  // Stall timer
  // ---------------------------------------------------------------------

  // Cleared on every phase change so each phase starts a fresh count
  assign tmr_clr = gtwiz_reset_all_sync || leave || (new_kind != kind_none);

  always_comb begin
    case (state)
      ch_pll:      tmr_limit = PLL_LIMIT;
      ch_wait_cdr: tmr_limit = CDR_LIMIT;
      default:     tmr_limit = SETTLE_LIMIT;
    endcase
  end

  settle_timer #(
    .WIDTH (TW)
  ) timer_i (
    .gtwiz_reset_clk_freerun_in (gtwiz_reset_clk_freerun_in),
    .clr                        (tmr_clr),
    .limit                      (tmr_limit),
    .sat                        (tmr_sat)
  );

  // ---------------------------------------------------------------------
  // State and reset outputs
  // ---------------------------------------------------------------------

  always_ff @(posedge gtwiz_reset_clk_freerun_in) begin
    if (gtwiz_reset_all_sync) begin
      state         <= ch_idle;
      kind          <= kind_none;
      user_dp_q     <= 1'b0;
      pll_reset     <= PLL_RESET_INIT;
      dp_reset      <= 1'b1;
      progdiv_reset <= 1'b1;
      userrdy       <= 1'b0;
      done          <= 1'b0;
    end else begin
      state     <= state_d;
      user_dp_q <= user_dp_req;
      if (new_kind != kind_none) begin
        // Datapath goes back into reset at once, the PLL waits for branch
        kind          <= new_kind;
        dp_reset      <= 1'b1;
        progdiv_reset <= 1'b1;
        userrdy       <= 1'b0;
        done          <= 1'b0;
      end else begin
        case (state)
          ch_branch: begin
            if (kind == kind_pll_and_datapath) pll_reset <= 1'b1;
          end
          ch_pll: begin
            if (leave) pll_reset <= 1'b0;
          end
          // Without a CDR the divider comes out of reset with the datapath
          ch_wait_lock: begin
            if (leave) begin
              dp_reset <= 1'b0;
              if (HAS_CDR == 0) progdiv_reset <= 1'b0;
            end
          end
          ch_wait_cdr: begin
            if (leave) progdiv_reset <= 1'b0;
          end
          ch_wait_userrdy: begin
            if (leave) userrdy <= 1'b1;
          end
          ch_wait_resetdone: begin
            if (leave) done <= 1'b1;
          end
          // Lost lock needs a new request, nothing restarts on its own
          ch_idle: begin
            if (!status.plllock) done <= 1'b0;
          end
          default: begin
          end
        endcase
      end
    end
  end

  a_userrdy_after_dp: assert property (
    @(posedge gtwiz_reset_clk_freerun_in) disable iff (gtwiz_reset_all_sync)
    userrdy |-> !dp_reset
  );

  a_done_needs_userrdy: assert property (
    @(posedge gtwiz_reset_clk_freerun_in) disable iff (gtwiz_reset_all_sync)
    done |-> userrdy
  );

endmodule

// File: verilog/gt_reset_io_pkg.sv
/* Request kind and packed transceiver status bundles */
package gt_reset_io_pkg;

  typedef enum logic [1:0] {
    kind_none             = 2'd0,
    kind_datapath         = 2'd1,
    kind_pll_and_datapath = 2'd2
  } reset_kind_t;

  typedef struct packed {
    logic plllock;
    logic userclk_active;
    logic resetdone;
  } tx_status_t;

  // CDR lock sits in the top bit so the shared fields keep their place
  typedef struct packed {
    logic cdrlock;
    logic plllock;
    logic userclk_active;
    logic resetdone;
  } rx_status_t;

endpackage

// File: verilog/gt_reset_params.svh
/* Timing and option macros for the transceiver reset helper */
`ifndef GT_RESET_PARAMS_SVH
`define GT_RESET_PARAMS_SVH

// Depth of every synchronizer chain into the free-running domain
`define GT_CDC_STAGES 3

// Settle stall before a synchronized input is sampled
// The stall lasts one cycle more than this count
`define GT_SETTLE_CYCLES 7

// Minimum PLL reset pulse, in free-running clock cycles
`define GT_PLL_RESET_CYCLES 15

// Longest wait for receive CDR lock before going on without it
`define GT_CDR_TIMEOUT_CYCLES 200

// Width of the shared stall timer, it must hold the largest count above
`define GT_TIMER_WIDTH 8

// Set to 1 when transmit and receive run from one PLL
// The transmit side then resets only its datapath
`define GT_SHARED_PLL 0

`endif

// File: verilog/gt_reset_state_pkg.sv
/* State encodings of the reset-all sequencer and the per-direction channel FSM */
package gt_reset_state_pkg;

  // Reset-all ordering, receive side first and transmit side second
  typedef enum logic [2:0] {
    seq_rx_pll  = 3'd0,
    seq_rx_wait = 3'd1,
    seq_tx_dp   = 3'd2,
    seq_tx_pll  = 3'd3,
    seq_tx_wait = 3'd4,
    seq_done    = 3'd5
  } all_state_t;

  // Channel FSM phases
  // Branch picks the entry point from the latched request kind
  typedef enum logic [2:0] {
    ch_branch         = 3'd0,
    ch_pll            = 3'd1,
    ch_datapath       = 3'd2,
    ch_wait_lock      = 3'd3,
    ch_wait_cdr       = 3'd4,
    ch_wait_userrdy   = 3'd5,
    ch_wait_resetdone = 3'd6,
    ch_idle           = 3'd7
  } chan_state_t;

endpackage

// File: verilog/gt_reset_top.sv
/* Reset helper top, with synchronizers, reset-all sequencer and
   the transmit and receive channel FSMs */
module gt_reset_top (
  input  logic gtwiz_reset_clk_freerun_in,
  input  logic gtwiz_reset_all_sync,
  input  logic tx_datapath_req,
  input  logic rx_datapath_req,
  input  logic userclk_tx_active,
  input  logic userclk_rx_active,
  input  logic plllock_tx,
  input  logic txresetdone,
  input  logic plllock_rx,
  input  logic rxcdrlock,
  input  logic rxresetdone,
  output logic pllreset_tx,
  output logic gttxreset,
  output logic txprogdivreset,
  output logic txuserrdy,
  output logic pllreset_rx,
  output logic gtrxreset,
  output logic rxprogdivreset,
  output logic rxuserrdy,
  output logic tx_done,
  output logic rx_done,
  output logic rx_cdr_stable
);

  import gt_reset_io_pkg::*;

  tx_status_t  tx_status_raw;
  tx_status_t  tx_status_sync;
  rx_status_t  rx_status_raw;
  rx_status_t  rx_status_sync;
  logic [1:0]  user_req_raw;
  logic [1:0]  user_req_sync;
  reset_kind_t tx_req;
  reset_kind_t rx_req;

  // ---------------------------------------------------------------------
  // Synchronizers for the transceiver status and user requests
  // ---------------------------------------------------------------------

  assign tx_status_raw.plllock        = plllock_tx;
  assign tx_status_raw.userclk_active = userclk_tx_active;
  assign tx_status_raw.resetdone      = txresetdone;

  assign rx_status_raw.cdrlock        = rxcdrlock;
  assign rx_status_raw.plllock        = plllock_rx;
  assign rx_status_raw.userclk_active = userclk_rx_active;
  assign rx_status_raw.resetdone      = rxresetdone;

  // Bit 1 is the transmit request, bit 0 the receive one
  assign user_req_raw = {tx_datapath_req, rx_datapath_req};

  level_sync #(
    .payload_t (tx_status_t)
  ) tx_status_sync_i (
    .gtwiz_reset_clk_freerun_in (gtwiz_reset_clk_freerun_in),
    .gtwiz_reset_all_sync       (gtwiz_reset_all_sync),
    .async_in                   (tx_status_raw),
    .sync_out                   (tx_status_sync)
  );

  level_sync #(
    .payload_t (rx_status_t)
  ) rx_status_sync_i (
    .gtwiz_reset_clk_freerun_in (gtwiz_reset_clk_freerun_in),
    .gtwiz_reset_all_sync       (gtwiz_reset_all_sync),
    .async_in                   (rx_status_raw),
    .sync_out                   (rx_status_sync)
  );

  level_sync #(
    .payload_t (logic [1:0])
  ) user_req_sync_i (
    .gtwiz_reset_clk_freerun_in (gtwiz_reset_clk_freerun_in),
    .gtwiz_reset_all_sync       (gtwiz_reset_all_sync),
    .async_in                   (user_req_raw),
    .sync_out                   (user_req_sync)
  );

  // ---------------------------------------------------------------------
  // Sequencer and channel FSMs
  // ---------------------------------------------------------------------

  reset_all_sequencer seq_i (
    .gtwiz_reset_clk_freerun_in (gtwiz_reset_clk_freerun_in),
    .gtwiz_reset_all_sync       (gtwiz_reset_all_sync),
    .tx_done                    (tx_done),
    .rx_done                    (rx_done),
    .tx_req                     (tx_req),
    .rx_req                     (rx_req)
  );

  chan_reset_fsm #(
    .HAS_CDR  (0),
    .status_t (tx_status_t)
  ) tx_fsm_i (
    .gtwiz_reset_clk_freerun_in (gtwiz_reset_clk_freerun_in),
    .gtwiz_reset_all_sync       (gtwiz_reset_all_sync),
    .req                        (tx_req),
    .user_dp_req                (user_req_sync[1]),
    .status                     (tx_status_sync),
    .resetdone_raw              (txresetdone),
    .pll_reset                  (pllreset_tx),
    .dp_reset                   (gttxreset),
    .progdiv_reset              (txprogdivreset),
    .userrdy                    (txuserrdy),
    .done                       (tx_done)
  );

  chan_reset_fsm #(
    .HAS_CDR  (1),
    .status_t (rx_status_t)
  ) rx_fsm_i (
    .gtwiz_reset_clk_freerun_in (gtwiz_reset_clk_freerun_in),
    .gtwiz_reset_all_sync       (gtwiz_reset_all_sync),
    .req                        (rx_req),
    .user_dp_req                (user_req_sync[0]),
    .status                     (rx_status_sync),
    .resetdone_raw              (rxresetdone),
    .pll_reset                  (pllreset_rx),
    .dp_reset                   (gtrxreset),
    .progdiv_reset              (rxprogdivreset),
    .userrdy                    (rxuserrdy),
    .done                       (rx_done)
  );

  // CDR stable is the synchronized lock as it stands, timeout or not
  assign rx_cdr_stable = rx_status_sync.cdrlock;

endmodule

// File: verilog/level_sync.sv
/* Multi-stage level synchronizer for any packed payload */
`include "gt_reset_params.svh"

module level_sync #(
  parameter type payload_t = logic
) (
  input  logic     gtwiz_reset_clk_freerun_in,
  input  logic     gtwiz_reset_all_sync,
  input  payload_t async_in,
  output payload_t sync_out
);

  localparam int STAGES = `GT_CDC_STAGES;

  // Stage 0 may go metastable, the later stages give it time to resolve
  payload_t sync_q [STAGES];

  always_ff @(posedge gtwiz_reset_clk_freerun_in) begin
    if (gtwiz_reset_all_sync) begin
      for (int i = 0; i < STAGES; i++) begin
        sync_q[i] <= '0;
      end
    end else begin
      sync_q[0] <= async_in;
      for (int i = 1; i < STAGES; i++) begin
        sync_q[i] <= sync_q[i-1];
      end
    end
  end

  // Every field shows up STAGES cycles after it changes at the input
  assign sync_out = sync_q[STAGES-1];

endmodule

// File: verilog/reset_all_sequencer.sv
/* Reset-all sequencer, receive PLL and datapath first, then the transmit side */
`include "gt_reset_params.svh"

module reset_all_sequencer (
  input  logic                         gtwiz_reset_clk_freerun_in,
  input  logic                         gtwiz_reset_all_sync,
  input  logic                         tx_done,
  input  logic                         rx_done,
  output gt_reset_io_pkg::reset_kind_t tx_req,
  output gt_reset_io_pkg::reset_kind_t rx_req
);

  import gt_reset_state_pkg::*;
  import gt_reset_io_pkg::*;

  all_state_t state;

  // ---------------------------------------------------------------------
  // Ordering FSM
  // ---------------------------------------------------------------------

  always_ff @(posedge gtwiz_reset_clk_freerun_in) begin
    if (gtwiz_reset_all_sync) begin
      // Sit on the first request so it goes out in the first free cycle
      state <= seq_rx_pll;
    end else begin
      case (state)
        seq_rx_pll: begin
          state <= seq_rx_wait;
        end
        // The receive FSM clears its done on the request edge,
        // so a high rx_done here is the new one
        seq_rx_wait: begin
          if (rx_done) begin
            state <= (`GT_SHARED_PLL != 0) ? seq_tx_dp : seq_tx_pll;
          end
        end
        seq_tx_dp, seq_tx_pll: begin
          state <= seq_tx_wait;
        end
        seq_tx_wait: begin
          if (tx_done) begin
            state <= seq_done;
          end
        end
        // Stay here until the next reset all
        default: begin
          state <= seq_done;
        end
      endcase
    end
  end

  // ---------------------------------------------------------------------
  // Request pulses
  // ---------------------------------------------------------------------

  // Each request state lasts exactly one cycle, which makes the pulse
  assign rx_req = (state == seq_rx_pll) ? kind_pll_and_datapath : kind_none;

  // A shared PLL was already reset by the receive side
  assign tx_req = (state == seq_tx_pll) ? kind_pll_and_datapath :
                  (state == seq_tx_dp)  ? kind_datapath : kind_none;

  a_one_req_at_a_time: assert property (
    @(posedge gtwiz_reset_clk_freerun_in) disable iff (gtwiz_reset_all_sync)
    !(tx_req != kind_none && rx_req != kind_none)
  );

endmodule

// File: verilog/settle_timer.sv
/* Clear-and-count saturating stall timer */
module settle_timer #(
  parameter int WIDTH = 8
) (
  input  logic             gtwiz_reset_clk_freerun_in,
  input  logic             clr,
  input  logic [WIDTH-1:0] limit,
  output logic             sat
);

  logic [WIDTH-1:0] ctr;

  // Clear wins over counting
  // The count stops at the limit, so sat then stays high until the next clear
  always_ff @(posedge gtwiz_reset_clk_freerun_in) begin
    if (clr) begin
      ctr <= '0;
    end else if (ctr != limit) begin
      ctr <= ctr + 1'b1;
    end
  end

  // With clear on the edge that enters a phase, sat is high in the
  // phase's cycle number limit, so the phase lasts limit+1 cycles
  assign sat = (ctr == limit);

  // Every limit in use is nonzero, so a fresh count can't be done at once
  a_no_sat_after_clr: assert property (
    @(posedge gtwiz_reset_clk_freerun_in) clr |=> !sat
  );

endmodule
